/* hw/gige_tx_macros.svh */
`ifndef GIGE_TX_MACROS_SVH
`define GIGE_TX_MACROS_SVH

// Buffer entries, also the credits the client holds after reset
`define GTX_BUF_DEPTH      8

// Line framing
`define GTX_PREAMBLE_LEN   7
`define GTX_PREAMBLE_BYTE  8'h55
`define GTX_SFD            8'hD5
`define GTX_MIN_PAYLOAD    60      // Bytes before FCS
`define GTX_IFG_LEN        12      // Idle bytes after last FCS byte

// Reflected CRC-32 (IEEE 802.3), result is complemented
`define GTX_CRC_POLY       32'hEDB8_8320
`define GTX_CRC_INIT       32'hFFFF_FFFF

`endif

/* hw/frame_pkg.sv */
`include "gige_tx_macros.svh"

// Client side of the transmit path
package frame_pkg;

   // One byte from the core, last marks the final payload byte
   typedef struct packed
   {
      logic [7:0] data;
      logic       last;
   } frame_beat_t;

   // Big enough to hold a full buffer worth of credits
   typedef logic [$clog2(`GTX_BUF_DEPTH + 1)-1:0] credit_cnt_t;

endpackage

/* hw/gmii_pkg.sv */
// Line side of the transmit path
package gmii_pkg;

   // What goes to the output registers in front of the pins
   typedef struct packed
   {
      logic [7:0] txd;
      logic       tx_en;
      logic       tx_er;
   } gmii_tx_t;

   // Kind of byte slot handed from framer to FCS stage
   typedef enum logic [2:0]
   {
      IDLE     = 3'd0,
      PREAMBLE = 3'd1,
      SFD      = 3'd2,
      DATA     = 3'd3,
      FCS_SLOT = 3'd4,    // Byte filled in by FCS stage
      ABORT    = 3'd5
   } slot_kind_t;

   typedef struct packed
   {
      slot_kind_t kind;
      logic [7:0] data;
   } line_slot_t;

endpackage

/* hw/tx_credit_buffer.sv */
`timescale 1ns/1ns
`include "gige_tx_macros.svh"

module tx_credit_buffer import frame_pkg::*;
(
   input  logic        GMII_GTX_CLK_int,
   input  logic        arst_n_i,
   input  logic        beat_valid_i,
   input  frame_beat_t beat_i,
   input  logic        pop_i,
   output frame_beat_t beat_o,
   output logic        empty_o,
   output logic        credit_o
);

   localparam int PTR_W = $clog2(`GTX_BUF_DEPTH);

   frame_beat_t      mem [`GTX_BUF_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   credit_cnt_t      count_q;
   logic             do_pop;

   // Wraps at the buffer depth, which need not be a power of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(`GTX_BUF_DEPTH - 1))
         return '0;
      else
         return ptr + 1'b1;
   endfunction

   assign empty_o = (count_q == '0);
   assign do_pop  = pop_i && !empty_o;   // Framer never pops empty, guard anyway
   assign beat_o  = mem[rd_ptr_q];       // First word fall through

   // Storage
   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (beat_valid_i)
         mem[wr_ptr_q] <= beat_i;
   end

   always_ff @(posedge GMII_GTX_CLK_int or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         credit_o <= 1'b0;
      end
      else
      begin
         if (beat_valid_i)
            wr_ptr_q <= next_ptr(wr_ptr_q);
         if (do_pop)
            rd_ptr_q <= next_ptr(rd_ptr_q);

         // Occupancy, no overflow check since credits bound the writes
         case ({beat_valid_i, do_pop})
            2'b10:
            begin
               count_q <= count_q + 1'b1;
            end
            2'b01:
            begin
               count_q <= count_q - 1'b1;
            end
            default:
            begin
               count_q <= count_q;
            end
         endcase

         // One credit back per byte taken
         credit_o <= do_pop;
      end
   end

endmodule

/* hw/tx_framer.sv */
`timescale 1ns/1ns
`include "gige_tx_macros.svh"

module tx_framer import frame_pkg::*, gmii_pkg::*;
(
   input  logic        GMII_GTX_CLK_int,
   input  logic        arst_n_i,
   input  frame_beat_t beat_i,
   input  logic        empty_i,
   output logic        pop_o,
   output line_slot_t  slot_o
);

   typedef enum logic [2:0]
   {
      ST_IDLE,
      ST_PREAMBLE,
      ST_SFD,
      ST_DATA,
      ST_PAD,
      ST_FCS,
      ST_DISCARD
   } state_t;

   localparam int PRE_W = $clog2(`GTX_PREAMBLE_LEN);
   localparam int LEN_W = $clog2(`GTX_MIN_PAYLOAD + 1);
   localparam int GAP_W = $clog2(`GTX_IFG_LEN + 1);

   state_t           state_q;
   state_t           state_d;
   logic [PRE_W-1:0] pre_cnt_q;
   logic [LEN_W-1:0] len_cnt_q;    // Saturates at minimum length
   logic [1:0]       fcs_cnt_q;
   logic [GAP_W-1:0] gap_cnt_q;
   logic             gap_load;
   logic             gap_done;

   assign gap_done = (gap_cnt_q == '0);

   always_comb
   begin
      state_d     = state_q;
      pop_o       = 1'b0;
      gap_load    = 1'b0;
      slot_o.kind = IDLE;
      slot_o.data = 8'h00;
      case (state_q)
         ST_IDLE:
         begin
            if (!empty_i && gap_done)
               state_d = ST_PREAMBLE;
         end
         ST_PREAMBLE:
         begin
            slot_o.kind = PREAMBLE;
            slot_o.data = `GTX_PREAMBLE_BYTE;
            if (pre_cnt_q == PRE_W'(`GTX_PREAMBLE_LEN - 1))
               state_d = ST_SFD;
         end
         ST_SFD:
         begin
            slot_o.kind = SFD;
            slot_o.data = `GTX_SFD;
            state_d     = ST_DATA;
         end
         ST_DATA:
         begin
            if (empty_i)
            begin
               // Underrun, kill the frame on the line
               slot_o.kind = ABORT;
               gap_load    = 1'b1;
               state_d     = ST_DISCARD;
            end
            else
            begin
               slot_o.kind = DATA;
               slot_o.data = beat_i.data;
               pop_o       = 1'b1;
               if (beat_i.last)
                  state_d = (len_cnt_q < LEN_W'(`GTX_MIN_PAYLOAD - 1)) ? ST_PAD : ST_FCS;
            end
         end
         ST_PAD:
         begin
            slot_o.kind = DATA;    // Zero byte
            if (len_cnt_q == LEN_W'(`GTX_MIN_PAYLOAD - 1))
               state_d = ST_FCS;
         end
         ST_FCS:
         begin
            slot_o.kind = FCS_SLOT;
            if (fcs_cnt_q == 2'd3)
            begin
               gap_load = 1'b1;
               state_d  = ST_IDLE;
            end
         end
         ST_DISCARD:
         begin
            // Drop the rest of the aborted frame, credits still flow back
            if (!empty_i)
            begin
               pop_o = 1'b1;
               if (beat_i.last)
                  state_d = ST_IDLE;
            end
         end
         default:
         begin
            state_d = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge GMII_GTX_CLK_int or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q   <= ST_IDLE;
         pre_cnt_q <= '0;
         len_cnt_q <= '0;
         fcs_cnt_q <= '0;
         gap_cnt_q <= '0;    // Gap already expired
      end
      else
      begin
         state_q <= state_d;

         if (state_q == ST_PREAMBLE)
            pre_cnt_q <= pre_cnt_q + 1'b1;
         else
            pre_cnt_q <= '0;

         if (state_q == ST_SFD)
            len_cnt_q <= '0;
         else if (((state_q == ST_DATA && pop_o) || state_q == ST_PAD) &&
                  len_cnt_q < LEN_W'(`GTX_MIN_PAYLOAD))
            len_cnt_q <= len_cnt_q + 1'b1;

         if (state_q == ST_FCS)
            fcs_cnt_q <= fcs_cnt_q + 1'b1;
         else
            fcs_cnt_q <= '0;

         if (gap_load)
            gap_cnt_q <= GAP_W'(`GTX_IFG_LEN);
         else if (!gap_done)
            gap_cnt_q <= gap_cnt_q - 1'b1;
      end
   end

endmodule

/* hw/tx_fcs_stage.sv */
`timescale 1ns/1ns
`include "gige_tx_macros.svh"

module tx_fcs_stage import gmii_pkg::*;
(
   input  logic       GMII_GTX_CLK_int,
   input  logic       arst_n_i,
   input  line_slot_t slot_i,
   output gmii_tx_t   gmii_o
);

   gmii_tx_t    gmii_q;
   logic [31:0] crc_q;
   logic [31:0] crc_fin;
   logic [1:0]  fcs_sel_q;    // Which FCS byte goes out next
   logic [7:0]  fcs_byte;

   // One byte through the reflected CRC, LSB first
   function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] d);
      logic [31:0] c;
      c = crc ^ {24'h000000, d};
      for (int i = 0; i < 8; i++)
      begin
         if (c[0])
            c = (c >> 1) ^ `GTX_CRC_POLY;
         else
            c = c >> 1;
      end
      return c;
   endfunction

   assign crc_fin  = ~crc_q;
   assign fcs_byte = crc_fin[8*fcs_sel_q +: 8];    // Low byte first
   assign gmii_o   = gmii_q;

   // Running CRC, restarted by every SFD
   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (slot_i.kind == SFD)
         crc_q <= `GTX_CRC_INIT;
      else if (slot_i.kind == DATA)
         crc_q <= crc_byte(crc_q, slot_i.data);
   end

   always_ff @(posedge GMII_GTX_CLK_int or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         gmii_q    <= '0;
         fcs_sel_q <= '0;
      end
      else
      begin
         case (slot_i.kind)
            PREAMBLE:
            begin
               gmii_q <= '{txd: slot_i.data, tx_en: 1'b1, tx_er: 1'b0};
            end
            SFD:
            begin
               gmii_q    <= '{txd: slot_i.data, tx_en: 1'b1, tx_er: 1'b0};
               fcs_sel_q <= '0;
            end
            DATA:
            begin
               gmii_q <= '{txd: slot_i.data, tx_en: 1'b1, tx_er: 1'b0};
            end
            FCS_SLOT:
            begin
               gmii_q    <= '{txd: fcs_byte, tx_en: 1'b1, tx_er: 1'b0};
               fcs_sel_q <= fcs_sel_q + 1'b1;
            end
            ABORT:
            begin
               // Error propagation to the PHY
               gmii_q <= '{txd: 8'h00, tx_en: 1'b1, tx_er: 1'b1};
            end
            default:
            begin
               gmii_q <= '0;    // Idle on the line
            end
         endcase
      end
   end

endmodule

/* hw/gige_tx_top.sv */
`timescale 1ns/1ns

module gige_tx_top import frame_pkg::*, gmii_pkg::*;
(
   input  logic        GMII_GTX_CLK_int,
   input  logic        arst_n_i,
   input  logic        beat_valid_i,
   input  frame_beat_t beat_i,
   output logic        credit_o,
   output gmii_tx_t    gmii_o
);

   frame_beat_t buf_beat;
   logic        buf_empty;
   logic        buf_pop;
   line_slot_t  line_slot;    // Framer to FCS stage, one per cycle

   // Byte buffer, credits back to the core
   tx_credit_buffer buffer_i
   (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .arst_n_i         (arst_n_i),
      .beat_valid_i     (beat_valid_i),
      .beat_i           (beat_i),
      .pop_i            (buf_pop),
      .beat_o           (buf_beat),
      .empty_o          (buf_empty),
      .credit_o         (credit_o)
   );

   // Preamble, padding, gap and underrun handling
   tx_framer framer_i
   (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .arst_n_i         (arst_n_i),
      .beat_i           (buf_beat),
      .empty_i          (buf_empty),
      .pop_o            (buf_pop),
      .slot_o           (line_slot)
   );

   // CRC and registered GMII outputs
   tx_fcs_stage fcs_i
   (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .arst_n_i         (arst_n_i),
      .slot_i           (line_slot),
      .gmii_o           (gmii_o)
   );

endmodule

/* bench/gige_tx_properties.sv */
`timescale 1ns/1ns
`include "gige_tx_macros.svh"

module gige_tx_properties import gmii_pkg::*;
(
   input logic     GMII_GTX_CLK_int,
   input logic     arst_n_i,
   input logic     credit_i,
   input gmii_tx_t gmii_i
);

   int fail_count = 0;    // Failed assertions so far

   // Error code only ever sent inside a frame
   er_needs_en: assert property (@(posedge GMII_GTX_CLK_int) disable iff (!arst_n_i)
      gmii_i.tx_er |-> gmii_i.tx_en)
   else
   begin
      $error("tx_er asserted while tx_en is low");
      fail_count++;
   end

   // Outputs quiet while reset is held
   quiet_in_reset: assert property (@(posedge GMII_GTX_CLK_int)
      !arst_n_i |-> (!gmii_i.tx_en && !credit_i))
   else
   begin
      $error("tx_en or credit pulse active during reset");
      fail_count++;
   end

   // Inter-frame gap on the line
   gap_after_frame: assert property (@(posedge GMII_GTX_CLK_int) disable iff (!arst_n_i)
      $fell(gmii_i.tx_en) |-> !gmii_i.tx_en [*`GTX_IFG_LEN])
   else
   begin
      $error("tx_en rose again before the inter-frame gap ran out");
      fail_count++;
   end

endmodule

bind gige_tx_top gige_tx_properties props_i
(
   .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
   .arst_n_i         (arst_n_i),
   .credit_i         (credit_o),
   .gmii_i           (gmii_o)
);

/* bench/gige_tx_tb.sv */
`timescale 1ns/1ns
`include "gige_tx_macros.svh"

module gige_tx_tb import frame_pkg::*, gmii_pkg::*;
();

   localparam int NUM_FRAMES     = 8;
   localparam int STALL_CYCLES   = 24;     // Long enough to drain the buffer
   localparam int IDLE_LIMIT     = 200;
   localparam int RISE_LIMIT     = 400;
   localparam int MAX_LINE_BYTES = 200;

   // Stall is the byte index where the sender pauses, zero for none
   typedef struct packed
   {
      int   len;
      logic counting;
      int   stall;
      int   line_bytes;    // Bytes with tx_en high
   } frame_entry_t;

   localparam frame_entry_t FRAMES [NUM_FRAMES] = '{
      '{len: 64,  counting: 1'b0, stall: 0,  line_bytes: 76},
      '{len: 100, counting: 1'b1, stall: 0,  line_bytes: 112},
      '{len: 1,   counting: 1'b1, stall: 0,  line_bytes: 72},
      '{len: 45,  counting: 1'b0, stall: 0,  line_bytes: 72},
      '{len: 59,  counting: 1'b0, stall: 0,  line_bytes: 72},
      '{len: 80,  counting: 1'b1, stall: 30, line_bytes: 39},
      '{len: 72,  counting: 1'b0, stall: 0,  line_bytes: 84},
      '{len: 60,  counting: 1'b1, stall: 0,  line_bytes: 72}
   };

   logic        GMII_GTX_CLK_int;
   logic        arst_n_i;
   logic        beat_valid_i;
   frame_beat_t beat_i;
   logic        credit_o;
   gmii_tx_t    gmii_o;

   int          seed;
   int          credits;
   int          value_errors;
   int          protocol_errors;
   int          timeouts;
   bit          rx_done;
   logic [7:0]  pay_q [$];
   int          frame_off [NUM_FRAMES];
   gmii_tx_t    exp_q [$];

   gige_tx_top gige_tx_top_i
   (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .arst_n_i         (arst_n_i),
      .beat_valid_i     (beat_valid_i),
      .beat_i           (beat_i),
      .credit_o         (credit_o),
      .gmii_o           (gmii_o)
   );

   always #20 GMII_GTX_CLK_int = ~GMII_GTX_CLK_int;

   // Standard reflected CRC-32, one bit at a time
   function automatic logic [31:0] crc_next(input logic [31:0] crc, input logic [7:0] b);
      logic [31:0] r;
      logic        fb;
      r = crc;
      for (int i = 0; i < 8; i++)
      begin
         fb = r[0] ^ b[i];
         r  = {1'b0, r[31:1]};
         if (fb)
            r = r ^ 32'hEDB8_8320;
      end
      return r;
   endfunction

   function automatic gmii_tx_t line_byte(input logic [7:0] d, input logic er);
      return '{txd: d, tx_en: 1'b1, tx_er: er};
   endfunction

   function automatic void fill_payloads();
      logic [7:0] b;
      pay_q.delete();
      for (int f = 0; f < NUM_FRAMES; f++)
      begin
         frame_off[f] = pay_q.size();
         for (int i = 0; i < FRAMES[f].len; i++)
         begin
            if (FRAMES[f].counting)
               b = 8'(i);
            else
               b = 8'($random(seed));
            pay_q.push_back(b);
         end
      end
   endfunction

   // Line image of one table frame
   function automatic void build_expected(input int f);
      logic [31:0] crc;
      logic [7:0]  b;
      int          n;
      exp_q.delete();
      for (int i = 0; i < `GTX_PREAMBLE_LEN; i++)
         exp_q.push_back(line_byte(8'h55, 1'b0));
      exp_q.push_back(line_byte(8'hD5, 1'b0));
      if (FRAMES[f].stall != 0)
      begin
         for (int i = 0; i < FRAMES[f].stall; i++)
            exp_q.push_back(line_byte(pay_q[frame_off[f] + i], 1'b0));
         exp_q.push_back(line_byte(8'h00, 1'b1));    // Underrun abort
         return;
      end
      crc = 32'hFFFF_FFFF;
      n   = (FRAMES[f].len < `GTX_MIN_PAYLOAD) ? `GTX_MIN_PAYLOAD : FRAMES[f].len;
      for (int i = 0; i < n; i++)
      begin
         b   = (i < FRAMES[f].len) ? pay_q[frame_off[f] + i] : 8'h00;
         crc = crc_next(crc, b);
         exp_q.push_back(line_byte(b, 1'b0));
      end
      crc = ~crc;
      for (int k = 0; k < 4; k++)
         exp_q.push_back(line_byte(crc[8*k +: 8], 1'b0));    // Low byte first
   endfunction

   task automatic check_gmii(input string name, input gmii_tx_t exp, input gmii_tx_t act);
      if (act !== exp)
      begin
         $display("[ERROR] %s: expected txd=%02h en=%b er=%b, actual txd=%02h en=%b er=%b",
                  name, exp.txd, exp.tx_en, exp.tx_er, act.txd, act.tx_en, act.tx_er);
         value_errors++;
      end
   endtask

   task automatic check_credits(input string name, input credit_cnt_t exp,
                                input credit_cnt_t act);
      if (act !== exp)
      begin
         $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
         value_errors++;
      end
   endtask

   // Client side, spends one credit per beat until the line side has seen every frame
   task automatic send_all();
      int f;
      int pos;
      int stall_left;
      bit stalled;
      bit sent;
      int idle_cnt;
      f          = 0;
      pos        = 0;
      stall_left = 0;
      stalled    = 1'b0;
      idle_cnt   = 0;
      while (f < NUM_FRAMES || !rx_done)
      begin
         @(negedge GMII_GTX_CLK_int);
         sent         = 1'b0;
         beat_valid_i = 1'b0;
         beat_i       = '0;
         if (credit_o)
            credits++;
         if (credits > `GTX_BUF_DEPTH)
         begin
            $display("More credits returned than the buffer holds (%0d)", credits);
            protocol_errors++;
            break;
         end
         if (f < NUM_FRAMES)
         begin
            if (stall_left > 0)
               stall_left--;
            else if (FRAMES[f].stall != 0 && pos == FRAMES[f].stall && !stalled)
            begin
               stalled    = 1'b1;
               stall_left = STALL_CYCLES;
            end
            else if (credits > 0)
            begin
               beat_i.data  = pay_q[frame_off[f] + pos];
               beat_i.last  = (pos == FRAMES[f].len - 1);
               beat_valid_i = 1'b1;
               sent         = 1'b1;
               credits--;
               pos++;
               if (pos == FRAMES[f].len)
               begin
                  f++;
                  pos     = 0;
                  stalled = 1'b0;
               end
            end
         end
         idle_cnt = (sent || credit_o) ? 0 : idle_cnt + 1;
         if (idle_cnt > IDLE_LIMIT)
         begin
            $display("Sender timed out, no credit came back for %0d cycles", IDLE_LIMIT);
            timeouts++;
            break;
         end
      end
      beat_valid_i = 1'b0;
   endtask

   // Line side, one frame per table entry while tx_en is high
   task automatic receive_all();
      int idle;
      int waited;
      int n;
      @(negedge GMII_GTX_CLK_int);
      for (int f = 0; f < NUM_FRAMES; f++)
      begin
         build_expected(f);
         idle   = 0;
         waited = 0;
         while (!gmii_o.tx_en && waited < RISE_LIMIT)
         begin
            idle++;
            waited++;
            @(negedge GMII_GTX_CLK_int);
         end
         if (!gmii_o.tx_en)
         begin
            $display("Frame %0d never started on the line", f);
            timeouts++;
            return;
         end
         if (f > 0 && idle < `GTX_IFG_LEN)
         begin
            $display("Only %0d idle cycles before frame %0d", idle, f);
            protocol_errors++;
         end
         n = 0;
         while (gmii_o.tx_en && n < MAX_LINE_BYTES)
         begin
            if (n < exp_q.size())
               check_gmii($sformatf("frame %0d byte %0d", f, n), exp_q[n], gmii_o);
            n++;
            @(negedge GMII_GTX_CLK_int);
         end
         if (gmii_o.tx_en)
         begin
            $display("Frame %0d did not end within %0d bytes", f, MAX_LINE_BYTES);
            timeouts++;
            return;
         end
         if (n != FRAMES[f].line_bytes)
         begin
            $display("[ERROR] frame %0d length: expected %0d, actual %0d",
                     f, FRAMES[f].line_bytes, n);
            value_errors++;
         end
      end
   endtask

   initial
   begin
      GMII_GTX_CLK_int = 1'b0;
      arst_n_i         = 1'b0;
      beat_valid_i     = 1'b0;
      beat_i           = '0;
      seed             = 32'hbc39_3f7b;
      value_errors     = 0;
      protocol_errors  = 0;
      timeouts         = 0;
      rx_done          = 1'b0;
      credits          = `GTX_BUF_DEPTH;
      fill_payloads();
      repeat (10) @(negedge GMII_GTX_CLK_int);
      arst_n_i = 1'b1;
      fork
         send_all();
         begin
            receive_all();
            rx_done = 1'b1;    // Every credit of the last frame is back by now
         end
      join
      check_credits("credits after drain", credit_cnt_t'(`GTX_BUF_DEPTH),
                    credit_cnt_t'(credits));
      $display("Errors: %0d value, %0d protocol, %0d timeouts, %0d assertion",
               value_errors, protocol_errors, timeouts, gige_tx_top_i.props_i.fail_count);
      if (value_errors + protocol_errors + timeouts + gige_tx_top_i.props_i.fail_count == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+hw
hw/frame_pkg.sv
hw/gmii_pkg.sv
hw/tx_credit_buffer.sv
hw/tx_framer.sv
hw/tx_fcs_stage.sv
hw/gige_tx_top.sv
bench/gige_tx_properties.sv
bench/gige_tx_tb.sv
